// ==== synapse_pkg.sv ====
package synapse_pkg;

    // data, address and instruction word.
    typedef logic [15:0] word_t;

    // register index from instruction bits 11..8.
    typedef logic [3:0] reg_idx_t;

    // immediate from instruction bits 7..0.
    typedef logic [7:0] imm_t;

    // opcode from instruction bits 15..12.
    // codes without a member run as a no-op.
    typedef enum logic [3:0] {
        OP_LDI  = 4'h1,
        OP_ADDI = 4'h2,
        OP_LDA  = 4'h3,
        OP_ADD  = 4'h4,
        OP_STA  = 4'h5,
        OP_JMP  = 4'h6,
        OP_JNZ  = 4'h7,
        OP_HALT = 4'hf
    } opcode_t;

    typedef enum logic [1:0] {
        FETCH,
        EXECUTE,
        HALTED
    } core_state_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        DONE
    } visor_state_t;

    // address of the completion record.
    localparam word_t HALT_ADDR = 16'hffff;

endpackage

// ==== target_if.sv ====
`timescale 1ns/100ps

interface target_if import synapse_pkg::*; ();

    word_t code_addr;
    word_t code_in;
    logic  code_ready;
    logic  peek_load;
    word_t store_data;
    word_t exec_pc;
    logic  halted;

    modport core (
        output code_addr, peek_load, store_data, exec_pc, halted,
        input  code_in, code_ready
    );

    modport visor (
        input  code_addr, peek_load, store_data, exec_pc, halted,
        output code_in, code_ready
    );

endinterface

// ==== code_rom.sv ====
`timescale 1ns/100ps

module code_rom import synapse_pkg::*; (
    input  word_t addr,
    output word_t data
);

    // r1 holds the addend, r2 the loop count and r3 the loop counter.
    // the running sum lives in the peek register r7 and the final sum in r0.
    always_comb begin
        case (addr)
            // copy the loop count into the counter.
            16'h0000: data = {OP_LDA, 4'd2, 8'h00};
            16'h0001: data = {OP_STA, 4'd3, 8'h00};

            // the loop body adds the addend to the sum held in the peek register.
            16'h0002: data = {OP_LDA, 4'd7, 8'h00};
            16'h0003: data = {OP_ADD, 4'd1, 8'h00};
            16'h0004: data = {OP_STA, 4'd7, 8'h00};

            // count down and repeat while nonzero.
            16'h0005: data = {OP_LDA, 4'd3, 8'h00};
            16'h0006: data = {OP_ADDI, 4'd0, 8'hff};
            16'h0007: data = {OP_STA, 4'd3, 8'h00};
            16'h0008: data = {OP_JNZ, 4'd0, 8'h02};

            // publish the final sum and stop.
            16'h0009: data = {OP_LDA, 4'd7, 8'h00};
            16'h000a: data = {OP_STA, 4'd0, 8'h00};
            16'h000b: data = {OP_HALT, 4'd0, 8'h00};

            // anything past the program stops the target.
            default:  data = {OP_HALT, 4'd0, 8'h00};
        endcase
    end

endmodule

// ==== synapse_core.sv ====
`timescale 1ns/100ps

module synapse_core import synapse_pkg::*; #(
    parameter int num_regs = 8
) (
    input  logic                sysclk,
    input  logic                rst_n,
    target_if.core              bus,
    input  word_t               r [num_regs-1],
    input  word_t               peek_data,
    output logic [num_regs-2:0] r_read,
    output logic [num_regs-2:0] r_load,
    output word_t               r_load_data
);

    // the top register index belongs to the supervisor.
    localparam int peek_idx = num_regs - 1;

    core_state_t state;
    word_t       pc;
    word_t       acc;
    word_t       ir;
    word_t       exec_pc;

    opcode_t     op;
    reg_idx_t    idx;
    imm_t        imm;
    word_t       imm_sext;
    word_t       src_val;
    logic        executing;
    logic        is_peek;
    logic        fetch_done;

    // instruction fields.
    assign op       = opcode_t'(ir[15:12]);
    assign idx      = ir[11:8];
    assign imm      = ir[7:0];
    assign imm_sext = {{8{imm[7]}}, imm};

    assign executing  = (state == EXECUTE);
    assign is_peek    = (idx == reg_idx_t'(peek_idx));
    assign fetch_done = (state == FETCH) && bus.code_ready;

    // operand select and register file strobes.
    // indices above the peek register read as zero and strobe nothing.
    always_comb begin
        src_val = '0;
        r_read  = '0;
        r_load  = '0;
        if (is_peek) begin
            src_val = peek_data;
        end
        for (int i = 0; i < peek_idx; i++) begin
            if (idx == reg_idx_t'(i)) begin
                src_val   = r[i];
                r_read[i] = executing && (op == OP_LDA || op == OP_ADD);
                r_load[i] = executing && (op == OP_STA);
            end
        end
    end

    assign r_load_data = acc;

    // supervisor side.
    assign bus.code_addr  = pc;
    assign bus.exec_pc    = exec_pc;
    assign bus.store_data = acc;
    assign bus.peek_load  = executing && (op == OP_STA) && is_peek;
    assign bus.halted     = (state == HALTED);

    // sequencer and datapath.
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FETCH;
            pc    <= '0;
            acc   <= '0;
        end else begin
            case (state)
                FETCH: begin
                    // wait here while the supervisor withholds code.
                    if (bus.code_ready) begin
                        pc    <= pc + 16'd1;
                        state <= EXECUTE;
                    end
                end

                EXECUTE: begin
                    state <= FETCH;
                    case (op)
                        OP_LDI: begin
                            acc <= {8'h00, imm};
                        end
                        OP_ADDI: begin
                            acc <= acc + imm_sext;
                        end
                        OP_LDA: begin
                            acc <= src_val;
                        end
                        OP_ADD: begin
                            acc <= acc + src_val;
                        end
                        OP_JMP: begin
                            pc <= {8'h00, imm};
                        end
                        OP_JNZ: begin
                            if (acc != '0) begin
                                pc <= {8'h00, imm};
                            end
                        end
                        OP_HALT: begin
                            state <= HALTED;
                        end
                        // STA only strobes; other codes do nothing.
                        default: begin
                        end
                    endcase
                end

                default: begin
                    state <= HALTED;
                end
            endcase
        end
    end

    // instruction register and the address it came from.
    always_ff @(posedge sysclk) begin
        if (fetch_done) begin
            ir      <= bus.code_in;
            exec_pc <= pc;
        end
    end

endmodule

// ==== debug_visor.sv ====
`timescale 1ns/100ps

module debug_visor import synapse_pkg::*; #(
    parameter int num_regs = 8
) (
    input  logic    sysclk,
    input  logic    rst_n,
    target_if.visor bus,
    input  word_t   rom_data,
    output word_t   peek_data,
    output word_t   av_address,
    output word_t   av_writedata,
    output logic    av_write,
    input  logic    av_waitrequest
);

    visor_state_t state;
    logic         halted_q;
    logic         halt_rise;
    logic         xfer_done;

    assign halt_rise = bus.halted && !halted_q;

    // avalon transfer ends on write with no wait.
    assign av_write  = (state == WRITE);
    assign xfer_done = av_write && !av_waitrequest;

    // code passes straight from the ROM.
    // fetches are held off while a record is outstanding.
    assign bus.code_in    = rom_data;
    assign bus.code_ready = (state == IDLE);

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            halted_q  <= 1'b0;
            peek_data <= '0;
        end else begin
            halted_q <= bus.halted;

            if (bus.peek_load) begin
                peek_data <= bus.store_data;
            end

            case (state)
                IDLE: begin
                    if (bus.peek_load || halt_rise) begin
                        state <= WRITE;
                    end
                end

                WRITE: begin
                    // the halt record is the last one.
                    if (xfer_done) begin
                        state <= bus.halted ? DONE : IDLE;
                    end
                end

                default: begin
                    state <= DONE;
                end
            endcase
        end
    end

    // record contents stay steady until the transfer completes.
    always_ff @(posedge sysclk) begin
        if (state == IDLE) begin
            if (bus.peek_load) begin
                av_address   <= bus.exec_pc;
                av_writedata <= bus.store_data;
            end else if (halt_rise) begin
                av_address   <= HALT_ADDR;
                av_writedata <= bus.exec_pc;
            end
        end
    end

endmodule

// ==== supervised_synapse.sv ====
`timescale 1ns/100ps

module supervised_synapse import synapse_pkg::*; #(
    parameter int num_regs = 8
) (
    input  logic                sysclk,
    input  logic                rst_n,

    // external register file without the peek register.
    input  word_t               r [num_regs-1],
    output logic [num_regs-2:0] r_read,
    output logic [num_regs-2:0] r_load,
    output word_t               r_load_data,

    // avalon-mm master for trace and completion records.
    output word_t               av_address,
    output word_t               av_writedata,
    output logic                av_write,
    input  logic                av_waitrequest
);

    target_if tgt ();

    word_t rom_data;
    word_t peek_data;

    code_rom rom (
        .addr (tgt.code_addr),
        .data (rom_data)
    );

    synapse_core #(
        .num_regs (num_regs)
    ) target (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .bus         (tgt.core),
        .r           (r),
        .peek_data   (peek_data),
        .r_read      (r_read),
        .r_load      (r_load),
        .r_load_data (r_load_data)
    );

    debug_visor #(
        .num_regs (num_regs)
    ) visr (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .bus            (tgt.visor),
        .rom_data       (rom_data),
        .peek_data      (peek_data),
        .av_address     (av_address),
        .av_writedata   (av_writedata),
        .av_write       (av_write),
        .av_waitrequest (av_waitrequest)
    );

endmodule

// ==== tb_supervised_synapse.sv ====
`timescale 1ns/100ps

module tb_supervised_synapse import synapse_pkg::*; ();

    localparam int num_regs = 8;
    localparam logic [31:0] lfsr_seed = 32'h7488_5c37;

    typedef logic [num_regs-2:0] strobe_t;

    // the program reads r1, r2 and r3 and stores r0 and r3.
    localparam strobe_t read_mask = strobe_t'(14);
    localparam strobe_t load_mask = strobe_t'(9);

    logic    sysclk = 1'b0;
    logic    rst_n;
    word_t   r_model [num_regs-1];
    strobe_t r_read;
    strobe_t r_load;
    word_t   r_load_data;
    word_t   av_address;
    word_t   av_writedata;
    logic    av_write;
    logic    av_waitrequest;

    // stimulus memory holds r0..r6, the record count and then address and data pairs.
    word_t stim_mem [0:63];
    int    exp_count;
    word_t expected_sum;

    // monitor state.
    int    rec_count = 0;
    logic  all_done = 1'b0;
    logic  hold_prev = 1'b0;
    word_t prev_addr;
    word_t prev_data;
    int    sum_writes = 0;
    int    load_seq = 0;
    int    pend_idx = 0;
    word_t pend_data;

    supervised_synapse #(
        .num_regs (num_regs)
    ) dut (
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .r              (r_model),
        .r_read         (r_read),
        .r_load         (r_load),
        .r_load_data    (r_load_data),
        .av_address     (av_address),
        .av_writedata   (av_writedata),
        .av_write       (av_write),
        .av_waitrequest (av_waitrequest)
    );

    always #20 sysclk = ~sysclk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0.1f ns: %s is %h, expected %h",
                                $realtime, what, got, exp));
        end
    endtask

    task automatic check_strobe(input strobe_t got, input strobe_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0.1f ns: %s is %b, expected %b",
                                $realtime, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0.1f ns: %s is %b, expected %b",
                                $realtime, what, got, exp));
        end
    endtask

    // inputs change 2 ns after the rising edge.
    initial begin : drive_inputs
        logic [31:0] lfsr;
        logic        b0;
        logic        b1;
        int          applied_seq;
        $readmemh("tb_stimulus.txt", stim_mem);
        for (int i = 0; i < num_regs - 1; i++) begin
            r_model[i] = stim_mem[i];
        end
        exp_count      = int'(stim_mem[7]);
        // the program adds r1 to the peek register r2 times.
        expected_sum   = stim_mem[1] * stim_mem[2];
        av_waitrequest = 1'b0;
        lfsr           = lfsr_seed;
        applied_seq    = 0;
        forever begin
            @(posedge sysclk);
            #2;
            lfsr = lfsr_next(lfsr);
            b0   = lfsr[0];
            lfsr = lfsr_next(lfsr);
            b1   = lfsr[0];
            av_waitrequest = b0 | b1;
            // register file write lands after the store's execute edge.
            if (applied_seq != load_seq) begin
                r_model[pend_idx] = pend_data;
                applied_seq       = load_seq;
            end
        end
    end

    // sampled mid-cycle where every output has settled.
    always @(negedge sysclk) begin
        if (!rst_n) begin
            check_flag(av_write, 1'b0, "av_write during reset");
            check_strobe(r_read, '0, "r_read during reset");
            check_strobe(r_load, '0, "r_load during reset");
        end else begin
            check_flag($countones({r_read, r_load}) <= 1, 1'b1, "single register strobe");
            // strobes stay on the registers the program names.
            check_strobe(r_read & ~read_mask, '0, "r_read outside the program's sources");
            check_strobe(r_load & ~load_mask, '0, "r_load outside the program's targets");

            if (r_load != '0) begin
                for (int i = 0; i < num_regs - 1; i++) begin
                    if (r_load[i]) begin
                        pend_idx = i;
                    end
                end
                pend_data = r_load_data;
                load_seq++;
                if (r_load[0]) begin
                    check_word(r_load_data, expected_sum, "final sum stored to r0");
                    sum_writes++;
                end
            end

            if (av_write) begin
                check_flag(all_done, 1'b0, "av_write after the completion record");
                if (hold_prev) begin
                    check_word(av_address, prev_addr, "av_address under waitrequest");
                    check_word(av_writedata, prev_data, "av_writedata under waitrequest");
                end
                if (!av_waitrequest) begin
                    check_flag(rec_count < exp_count, 1'b1, "room for another record");
                    check_word(av_address, stim_mem[8 + 2 * rec_count],
                               $sformatf("record %0d address", rec_count));
                    check_word(av_writedata, stim_mem[9 + 2 * rec_count],
                               $sformatf("record %0d data", rec_count));
                    if (rec_count == exp_count - 1) begin
                        check_word(av_address, HALT_ADDR, "completion record address");
                        all_done = 1'b1;
                    end
                    rec_count++;
                end
            end else begin
                check_flag(hold_prev, 1'b0, "av_write dropped before its transfer completed");
            end

            hold_prev = av_write && av_waitrequest;
            prev_addr = av_address;
            prev_data = av_writedata;
        end
    end

    task automatic wait_for_records(input int max_cycles);
        int cycles;
        cycles = 0;
        while (rec_count < exp_count) begin
            @(posedge sysclk);
            cycles++;
            if (cycles > max_cycles) begin
                abort_run($sformatf("Timed out after %0d cycles waiting for %0d records, got %0d.",
                                    max_cycles, exp_count, rec_count));
            end
        end
    endtask

    // the monitor flags any av_write seen during this window.
    task automatic watch_quiet(input int window);
        int cycles;
        cycles = 0;
        while (cycles < window) begin
            @(posedge sysclk);
            cycles++;
        end
    endtask

    initial begin : main_sequence
        rst_n = 1'b0;
        repeat (4) @(posedge sysclk);
        #2;
        rst_n = 1'b1;

        // first fetch is still pending in this cycle.
        @(negedge sysclk);
        check_flag(av_write, 1'b0, "av_write before the first fetch");
        check_strobe(r_read, '0, "r_read before the first fetch");
        check_strobe(r_load, '0, "r_load before the first fetch");

        wait_for_records(4000);
        watch_quiet(100);

        if (sum_writes != 1) begin
            abort_run($sformatf("The final sum was stored to r0 %0d times instead of once.",
                                sum_writes));
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// ==== tb_stimulus.txt ====
// one 16-bit hex word per entry.
// r0..r6 start values, then the record count, then address and data of each record.
0000
1234
0004
5a5a
00c3
0e17
7f01
0005
// trace records: store pc, partial sum.
0004 1234
0004 2468
0004 369c
0004 48d0
// completion record: halt address, halt pc.
ffff 000b

// ==== tb.f ====
synapse_pkg.sv
target_if.sv
code_rom.sv
synapse_core.sv
debug_visor.sv
supervised_synapse.sv
tb_supervised_synapse.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator from the project root.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing -f tb.f --top-module tb_supervised_synapse \
    --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi
exit 0
